//--- design/max7219_pkg.sv
// MAX7219 register map and 16-bit frame layout for no-decode mode only; readback and display test are not supported
package max7219_pkg;

    typedef logic [7:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;

    // Digit registers follow ADDR_DIGIT0 at consecutive addresses
    localparam reg_addr_t ADDR_DIGIT0     = 8'h01;
    localparam reg_addr_t ADDR_DECODE     = 8'h09;
    localparam reg_addr_t ADDR_INTENSITY  = 8'h0a;
    localparam reg_addr_t ADDR_SCAN_LIMIT = 8'h0b;
    localparam reg_addr_t ADDR_SHUTDOWN   = 8'h0c;

    // Data written during the configuration sequence
    localparam reg_data_t DECODE_NONE     = 8'h00;
    localparam reg_data_t SCAN_ALL_DIGITS = 8'h07;
    localparam reg_data_t SHUTDOWN_NORMAL = 8'h01;

    // The address byte goes out first, both bytes MSB first
    typedef struct packed {
        reg_addr_t addr;
        reg_data_t data;
    } frame_t;

    localparam int FRAME_BITS = $bits(frame_t);

    // Decode mode, intensity, scan limit and normal operation
    localparam int NUM_INIT_FRAMES = 4;

    localparam int NUM_DIGITS = 8;

    typedef logic [$clog2(NUM_DIGITS)-1:0] digit_index_t;

    // Position whose decimal point is lit, digit register 3 on the wire
    localparam digit_index_t DP_DIGIT = 3'd2;

endpackage

//--- design/display_pkg.sv
// Value, BCD and segment types for a six-digit signed display; segment bits follow the MAX7219 no-decode order a..g
package display_pkg;

    typedef logic signed [23:0] display_value_t;

    typedef logic [19:0] magnitude_t;

    typedef logic [3:0] bcd_digit_t;

    // Hundred-thousands in the top nibble so the flat vector reads as plain BCD
    typedef struct packed {
        bcd_digit_t hundred_thousands;
        bcd_digit_t ten_thousands;
        bcd_digit_t thousands;
        bcd_digit_t hundreds;
        bcd_digit_t tens;
        bcd_digit_t ones;
    } bcd_t;

    // Bit 6 is segment a, bit 0 is segment g
    typedef logic [6:0] segments_t;

    // Codes above 9 that the encoder understands besides hex c to f
    localparam bcd_digit_t CODE_MINUS = 4'ha;
    localparam bcd_digit_t CODE_BLANK = 4'hb;

    // Largest magnitude that fits in six digits
    localparam magnitude_t MAX_MAGNITUDE = 20'd999999;

    localparam segments_t SEG_0     = 7'b1111110;
    localparam segments_t SEG_1     = 7'b0110000;
    localparam segments_t SEG_2     = 7'b1101101;
    localparam segments_t SEG_3     = 7'b1111001;
    localparam segments_t SEG_4     = 7'b0110011;
    localparam segments_t SEG_5     = 7'b1011011;
    localparam segments_t SEG_6     = 7'b1011111;
    localparam segments_t SEG_7     = 7'b1110000;
    localparam segments_t SEG_8     = 7'b1111111;
    localparam segments_t SEG_9     = 7'b1111011;
    localparam segments_t SEG_MINUS = 7'b0000001;
    localparam segments_t SEG_BLANK = 7'b0000000;
    localparam segments_t SEG_C     = 7'b1001110;
    localparam segments_t SEG_D     = 7'b0111101;
    localparam segments_t SEG_E     = 7'b1001111;
    localparam segments_t SEG_F     = 7'b1000111;

endpackage

//--- design/bin_to_bcd.sv
// Purely combinational double-dabble; magnitudes above 999999 overflow the sixth digit and give wrong BCD
`timescale 1ns/1ns

module bin_to_bcd (
    input  display_pkg::magnitude_t magnitude,
    output display_pkg::bcd_t       bcd
);
    import display_pkg::*;

    localparam int NUM_BCD = $bits(bcd_t) / $bits(bcd_digit_t);

    always_comb begin
        logic [$bits(bcd_t)-1:0] acc;

        acc = '0;
        for (int i = 0; i < $bits(magnitude_t); i++) begin
            // Any digit of 5 or more would pass 9 after the next shift
            for (int d = 0; d < NUM_BCD; d++) begin
                if (acc[4*d +: 4] >= 4'd5) begin
                    acc[4*d +: 4] = acc[4*d +: 4] + 4'd3;
                end
            end
            acc = {acc[$bits(bcd_t)-2:0], magnitude[$bits(magnitude_t)-1-i]};
        end
        bcd = bcd_t'(acc);
    end

endmodule

//--- design/segment_encoder.sv
// Character set of the display: 0-9, minus, blank and hex c-f; bit 6 drives segment a, decimal point not included
`timescale 1ns/1ns

module segment_encoder (
    input  display_pkg::bcd_digit_t code,
    output display_pkg::segments_t  segments
);
    import display_pkg::*;

    always_comb begin
        unique case (code)
            4'h0:       segments = SEG_0;
            4'h1:       segments = SEG_1;
            4'h2:       segments = SEG_2;
            4'h3:       segments = SEG_3;
            4'h4:       segments = SEG_4;
            4'h5:       segments = SEG_5;
            4'h6:       segments = SEG_6;
            4'h7:       segments = SEG_7;
            4'h8:       segments = SEG_8;
            4'h9:       segments = SEG_9;
            CODE_MINUS: segments = SEG_MINUS;
            CODE_BLANK: segments = SEG_BLANK;
            4'hc:       segments = SEG_C;
            4'hd:       segments = SEG_D;
            4'he:       segments = SEG_E;
            4'hf:       segments = SEG_F;
        endcase
    end

endmodule

//--- design/digit_formatter.sv
// Value is sampled every cycle with one cycle of latency; leading zeros are shown and magnitudes over 999999 are not supported
`timescale 1ns/1ns

module digit_formatter (
    input  logic                      clk,
    input  logic                      arst_n,
    input  display_pkg::display_value_t value,
    input  max7219_pkg::digit_index_t digit_index,
    output display_pkg::segments_t    digit_segments
);
    import display_pkg::*;
    import max7219_pkg::*;

    logic                               negative;
    logic [$bits(display_value_t)-1:0]  abs_value;
    magnitude_t                         magnitude;
    bcd_t                               bcd;
    bcd_digit_t                         code;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            negative  <= 1'b0;
            abs_value <= '0;
        end else begin
            negative <= value < 0;
            if (value < 0) begin
                abs_value <= -value;
            end else begin
                abs_value <= value;
            end
        end
    end

    assign magnitude = magnitude_t'(abs_value);

    bin_to_bcd u_bin_to_bcd (
        .magnitude (magnitude),
        .bcd       (bcd)
    );

    // Position 6 carries the sign, position 7 stays dark
    always_comb begin
        unique case (digit_index)
            3'd0:    code = bcd.ones;
            3'd1:    code = bcd.tens;
            3'd2:    code = bcd.hundreds;
            3'd3:    code = bcd.thousands;
            3'd4:    code = bcd.ten_thousands;
            3'd5:    code = bcd.hundred_thousands;
            3'd6:    code = negative ? CODE_MINUS : CODE_BLANK;
            default: code = CODE_BLANK;
        endcase
    end

    segment_encoder u_segment_encoder (
        .code     (code),
        .segments (digit_segments)
    );

    a_magnitude_in_range: assert property (
        @(posedge clk) disable iff (!arst_n) abs_value <= MAX_MAGNITUDE
    ) else $error("digit_formatter: magnitude %0d does not fit in six digits", abs_value);

endmodule

//--- design/frame_sequencer.sv
// Sends the four configuration frames once after reset, then refreshes digits 1 to 8 forever; waits on busy between frames
`timescale 1ns/1ns

module frame_sequencer #(
    parameter int BRIGHTNESS = 4
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      busy,
    input  display_pkg::segments_t    digit_segments,
    output max7219_pkg::digit_index_t digit_index,
    output max7219_pkg::frame_t       frame,
    output logic                      frame_load
);
    import max7219_pkg::*;

    localparam int INIT_W = $clog2(NUM_INIT_FRAMES);

    typedef enum logic [1:0] {
        INIT,
        WAIT_INIT,
        REFRESH,
        WAIT_REFRESH
    } state_t;

    state_t            state;
    logic [INIT_W-1:0] init_cnt;
    logic              issue;
    logic              frame_done;
    frame_t            next_frame;

    assign issue = (state == INIT || state == REFRESH) && !busy;

    // Busy only rises the cycle after the load pulse, so that cycle is not a finished frame
    assign frame_done = !busy && !frame_load;

    always_comb begin
        next_frame.addr = ADDR_DIGIT0 + reg_addr_t'(digit_index);
        next_frame.data = {digit_index == DP_DIGIT, digit_segments};
        if (state == INIT) begin
            unique case (init_cnt)
                2'd0:    next_frame = '{addr: ADDR_DECODE, data: DECODE_NONE};
                2'd1:    next_frame = '{addr: ADDR_INTENSITY, data: reg_data_t'(BRIGHTNESS)};
                2'd2:    next_frame = '{addr: ADDR_SCAN_LIMIT, data: SCAN_ALL_DIGITS};
                default: next_frame = '{addr: ADDR_SHUTDOWN, data: SHUTDOWN_NORMAL};
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= INIT;
            init_cnt    <= '0;
            digit_index <= '0;
            frame_load  <= 1'b0;
        end else begin
            frame_load <= issue;
            unique case (state)
                INIT: begin
                    if (issue) begin
                        state <= WAIT_INIT;
                    end
                end
                WAIT_INIT: begin
                    if (frame_done) begin
                        if (init_cnt == INIT_W'(NUM_INIT_FRAMES - 1)) begin
                            state <= REFRESH;
                        end else begin
                            init_cnt <= init_cnt + 1'b1;
                            state    <= INIT;
                        end
                    end
                end
                REFRESH: begin
                    if (issue) begin
                        state <= WAIT_REFRESH;
                    end
                end
                WAIT_REFRESH: begin
                    if (frame_done) begin
                        if (digit_index == digit_index_t'(NUM_DIGITS - 1)) begin
                            digit_index <= '0;
                        end else begin
                            digit_index <= digit_index + 1'b1;
                        end
                        state <= REFRESH;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            frame <= next_frame;
        end
    end

    a_no_load_while_busy: assert property (
        @(posedge clk) disable iff (!arst_n) frame_load |-> !busy
    ) else $error("frame_sequencer: frame_load raised while the serializer is busy");

endmodule

//--- design/frame_serializer.sv
// Sends one 16-bit frame in 35 ticks of CLK_DIV clk cycles each; frame_load is ignored unless the shifter is idle
`timescale 1ns/1ns

module frame_serializer #(
    parameter int CLK_DIV = 4
) (
    input  logic                clk,
    input  logic                arst_n,
    input  max7219_pkg::frame_t frame,
    input  logic                frame_load,
    output logic                busy,
    output logic                mosi,
    output logic                sclk,
    output logic                sel
);
    import max7219_pkg::*;

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam int CNT_W = $clog2(FRAME_BITS);

    typedef enum logic [2:0] {
        IDLE,
        SELECT,
        SHIFT,
        TAIL,
        DESELECT
    } state_t;

    state_t                state;
    logic [DIV_W-1:0]      div_cnt;
    logic                  tick;
    logic [CNT_W-1:0]      bit_cnt;
    logic                  half;
    logic [FRAME_BITS-1:0] shift_reg;

    // Free-running divider, so the first tick after a load may come early
    assign tick = div_cnt == DIV_W'(CLK_DIV - 1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
        end else if (tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= IDLE;
            busy    <= 1'b0;
            sel     <= 1'b1;
            sclk    <= 1'b0;
            mosi    <= 1'b0;
            bit_cnt <= '0;
            half    <= 1'b0;
        end else if (state == IDLE) begin
            if (frame_load) begin
                busy  <= 1'b1;
                state <= SELECT;
            end
        end else if (tick) begin
            unique case (state)
                SELECT: begin
                    sel     <= 1'b0;
                    bit_cnt <= '0;
                    half    <= 1'b0;
                    state   <= SHIFT;
                end
                SHIFT: begin
                    // First half puts the bit on mosi, second half clocks it in
                    if (!half) begin
                        mosi <= shift_reg[FRAME_BITS-1];
                        sclk <= 1'b0;
                        half <= 1'b1;
                    end else begin
                        sclk    <= 1'b1;
                        half    <= 1'b0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == CNT_W'(FRAME_BITS - 1)) begin
                            state <= TAIL;
                        end
                    end
                end
                TAIL: begin
                    sclk  <= 1'b0;
                    mosi  <= 1'b0;
                    state <= DESELECT;
                end
                default: begin
                    sel   <= 1'b1;
                    busy  <= 1'b0;
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && frame_load) begin
            shift_reg <= frame;
        end else if (tick && state == SHIFT && half) begin
            shift_reg <= {shift_reg[FRAME_BITS-2:0], 1'b0};
        end
    end

    a_sel_high_when_idle: assert property (
        @(posedge clk) disable iff (!arst_n) !busy |-> sel
    ) else $error("frame_serializer: sel low while not busy");

    a_sclk_low_when_deselected: assert property (
        @(posedge clk) disable iff (!arst_n) sel |-> !sclk
    ) else $error("frame_serializer: sclk high while sel is high");

endmodule

//--- design/max7219_display.sv
// Drives an eight-digit MAX7219 display from a signed value in one clk domain; serial rate is clk / (2 * CLK_DIV)
`timescale 1ns/1ns

module max7219_display #(
    parameter int CLK_DIV    = 4,
    parameter int BRIGHTNESS = 4
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  display_pkg::display_value_t value,
    output logic                        mosi,
    output logic                        sclk,
    output logic                        sel
);
    import display_pkg::*;
    import max7219_pkg::*;

    frame_t       frame;
    logic         frame_load;
    logic         busy;
    digit_index_t digit_index;
    segments_t    digit_segments;

    digit_formatter u_digit_formatter (
        .clk            (clk),
        .arst_n         (arst_n),
        .value          (value),
        .digit_index    (digit_index),
        .digit_segments (digit_segments)
    );

    frame_sequencer #(
        .BRIGHTNESS (BRIGHTNESS)
    ) u_frame_sequencer (
        .clk            (clk),
        .arst_n         (arst_n),
        .busy           (busy),
        .digit_segments (digit_segments),
        .digit_index    (digit_index),
        .frame          (frame),
        .frame_load     (frame_load)
    );

    frame_serializer #(
        .CLK_DIV (CLK_DIV)
    ) u_frame_serializer (
        .clk        (clk),
        .arst_n     (arst_n),
        .frame      (frame),
        .frame_load (frame_load),
        .busy       (busy),
        .mosi       (mosi),
        .sclk       (sclk),
        .sel        (sel)
    );

endmodule

//--- verif/max7219_checker.sv
// Decodes sel, sclk and mosi into frames; digit segments are judged only after one clean scan
`timescale 1ns/1ns

module max7219_checker #(
    parameter int BRIGHTNESS = 4
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  display_pkg::display_value_t value,
    input  logic [31:0]                 expected_codes,
    input  logic                        mosi,
    input  logic                        sclk,
    input  logic                        sel,
    output int                          clean_scans,
    output int                          frame_count,
    output int                          error_count
);
    import display_pkg::*;
    import max7219_pkg::*;

    logic                  prev_sel;
    logic                  prev_sclk;
    logic [FRAME_BITS-1:0] bits;
    int                    bit_count;
    logic                  scan_clean;
    display_value_t        last_value;

    function automatic int position_of(input int index);
        return (index - NUM_INIT_FRAMES) % NUM_DIGITS;
    endfunction

    function automatic segments_t code_segments(input logic [3:0] code);
        case (code)
            4'h0:    return SEG_0;
            4'h1:    return SEG_1;
            4'h2:    return SEG_2;
            4'h3:    return SEG_3;
            4'h4:    return SEG_4;
            4'h5:    return SEG_5;
            4'h6:    return SEG_6;
            4'h7:    return SEG_7;
            4'h8:    return SEG_8;
            4'h9:    return SEG_9;
            4'ha:    return SEG_MINUS;
            default: return SEG_BLANK;
        endcase
    endfunction

    // Four init frames, then digit registers 1 to 8 with the point on position 2
    function automatic frame_t frame_for(input int index, input logic [31:0] codes);
        frame_t f;
        int     pos;
        case (index)
            0:       f = 16'h0900;
            1:       f = {8'h0a, 8'(BRIGHTNESS)};
            2:       f = 16'h0b07;
            3:       f = 16'h0c01;
            default: begin
                pos    = position_of(index);
                f.addr = 8'(pos + 1);
                f.data = {pos == 2, code_segments(codes[4*pos +: 4])};
            end
        endcase
        return f;
    endfunction

    always @(posedge clk or negedge arst_n) begin : monitor
        frame_t      expected;
        logic [15:0] mask;
        logic        digit_frame;
        if (!arst_n) begin
            prev_sel    <= 1'b1;
            prev_sclk   <= 1'b0;
            bits        <= '0;
            bit_count   <= 0;
            scan_clean  <= 1'b0;
            clean_scans <= 0;
            frame_count <= 0;
            error_count <= 0;
            last_value  <= value;
        end else begin
            prev_sel    <= sel;
            prev_sclk   <= sclk;
            last_value  <= value;
            digit_frame = frame_count >= NUM_INIT_FRAMES;
            if (prev_sel && !sel) begin
                bit_count <= 0;
                if (digit_frame && position_of(frame_count) == 0) begin
                    scan_clean <= 1'b1;
                end
            end
            if (!sel && !prev_sclk && sclk) begin
                bits      <= {bits[FRAME_BITS-2:0], mosi};
                bit_count <= bit_count + 1;
            end
            if (!prev_sel && sel) begin
                expected = frame_for(frame_count, expected_codes);
                // Until a whole scan has passed, only the address and the point are known
                if (!digit_frame || (clean_scans >= 1 && value == last_value)) begin
                    mask = 16'hffff;
                end else begin
                    mask = 16'hff80;
                end
                if (bit_count != FRAME_BITS) begin
                    $display("Frame %0d had %0d clock pulses instead of %0d",
                             frame_count, bit_count, FRAME_BITS);
                    error_count <= error_count + 1;
                end else if ((bits & mask) != (expected & mask)) begin
                    $display("FAILED frame #%0d: expected %04h, got %04h",
                             frame_count, expected & mask, bits & mask);
                    error_count <= error_count + 1;
                end
                if (digit_frame && position_of(frame_count) == NUM_DIGITS - 1 && scan_clean) begin
                    clean_scans <= clean_scans + 1;
                end
                frame_count <= frame_count + 1;
            end
            if (value != last_value) begin
                scan_clean  <= 1'b0;
                clean_scans <= 0;
            end
        end
    end

endmodule

//--- verif/max7219_tb.sv
// Runs eight signed values with CLK_DIV 4 and BRIGHTNESS 4; each is held for two clean scans
`timescale 1ns/1ns

module max7219_tb;
    import display_pkg::*;
    import max7219_pkg::*;

    localparam int CLK_DIV     = 4;
    localparam int BRIGHTNESS  = 4;
    localparam int NUM_ROWS    = 8;
    localparam int CLK_PERIOD  = 20;
    localparam int FRAME_TICKS = 35;
    // A row may need a partial scan plus two full ones
    localparam longint TIMEOUT_NS = 2 * longint'(NUM_INIT_FRAMES + NUM_ROWS * 3 * NUM_DIGITS)
                                    * FRAME_TICKS * CLK_DIV * CLK_PERIOD;

    typedef struct packed {
        display_value_t value;
        logic [31:0]    codes;
    } stim_t;

    logic           clk = 1'b0;
    logic           arst_n;
    display_value_t value;
    logic [31:0]    expected_codes;
    logic           mosi;
    logic           sclk;
    logic           sel;
    int             clean_scans;
    int             frame_count;
    int             error_count;
    stim_t          stimulus [NUM_ROWS];
    integer         seed = 32'h5d5b;

    // Code nibbles run from position 7 down to 0, b is blank and a is minus
    function automatic logic [31:0] codes_for(input display_value_t v);
        logic [31:0] codes;
        int          mag;
        mag = (v < 0) ? -int'(v) : int'(v);
        for (int i = 0; i < 6; i++) begin
            codes[4*i +: 4] = 4'(mag % 10);
            mag = mag / 10;
        end
        codes[27:24] = (v < 0) ? 4'ha : 4'hb;
        codes[31:28] = 4'hb;
        return codes;
    endfunction

    task automatic load_table();
        display_value_t rnd;
        stimulus[0] = {display_value_t'(0), 32'hbb000000};
        stimulus[1] = {display_value_t'(7), 32'hbb000007};
        stimulus[2] = {display_value_t'(-5), 32'hba000005};
        stimulus[3] = {display_value_t'(123456), 32'hbb123456};
        stimulus[4] = {display_value_t'(-999999), 32'hba999999};
        stimulus[5] = {display_value_t'(999999), 32'hbb999999};
        stimulus[6] = {display_value_t'(402), 32'hbb000402};
        rnd = display_value_t'($random(seed) % 1000000);
        stimulus[7] = {rnd, codes_for(rnd)};
    endtask

    always #(CLK_PERIOD / 2) clk = ~clk;

    max7219_display #(
        .CLK_DIV    (CLK_DIV),
        .BRIGHTNESS (BRIGHTNESS)
    ) UUT (
        .clk    (clk),
        .arst_n (arst_n),
        .value  (value),
        .mosi   (mosi),
        .sclk   (sclk),
        .sel    (sel)
    );

    max7219_checker #(
        .BRIGHTNESS (BRIGHTNESS)
    ) u_checker (
        .clk            (clk),
        .arst_n         (arst_n),
        .value          (value),
        .expected_codes (expected_codes),
        .mosi           (mosi),
        .sclk           (sclk),
        .sel            (sel),
        .clean_scans    (clean_scans),
        .frame_count    (frame_count),
        .error_count    (error_count)
    );

    initial begin
        arst_n         = 1'b0;
        value          = '0;
        expected_codes = 32'hbb000000;
        load_table();
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        for (int row = 0; row < NUM_ROWS; row++) begin
            @(posedge clk);
            value          <= stimulus[row].value;
            expected_codes <= stimulus[row].codes;
            // The checker clears its scan count one cycle after the change
            repeat (2) @(posedge clk);
            wait (clean_scans >= 2);
        end
        $display("Frames seen: %0d, errors: %0d", frame_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, the display did not finish its refresh scans", TIMEOUT_NS);
        $display("Something failed");
        $finish;
    end

endmodule

//--- sim.f
design/max7219_pkg.sv
design/display_pkg.sv
design/bin_to_bcd.sv
design/segment_encoder.sv
design/digit_formatter.sv
design/frame_sequencer.sv
design/frame_serializer.sv
design/max7219_display.sv
verif/max7219_checker.sv
verif/max7219_tb.sv
